// File: rv_lite_consts.svh
// Sizing constants shared by the engine and its testbench
// RVL_IN_DEPTH also sets the sender's input credits after reset
// RVL_RES_CREDITS must not exceed what the receiver can absorb
`ifndef RV_LITE_CONSTS_SVH
`define RV_LITE_CONSTS_SVH

// Datapath
`define RVL_XLEN 32
`define RVL_NREGS 32

// Buffering and credits
`define RVL_IN_DEPTH 4
`define RVL_RES_DEPTH 4
`define RVL_RES_CREDITS 2

`endif

// File: rv_lite_pkg.sv
// Types shared between decode, execute and result
// Only the RV32I subset listed in alu_op_e is supported
`default_nettype none

`include "rv_lite_consts.svh"

package rv_lite_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_LUI,
    ALU_ILLEGAL
  } alu_op_e;

  typedef logic [4:0] reg_addr_t;

  typedef struct packed {
    alu_op_e          op;
    reg_addr_t        rd;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    logic [31:0]      imm;
    logic             use_imm;
    logic             illegal;
  } decoded_op_t;

  typedef struct packed {
    reg_addr_t             rd;
    logic [`RVL_XLEN-1:0]  value;
    logic                  illegal;
  } result_t;

endpackage

`default_nettype wire

// File: rv_lite_op_if.sv
// Decoded operation handshake, decode to execute
// op must stay stable while valid is high and ready is low
`default_nettype none

interface rv_lite_op_if;
  import rv_lite_pkg::*;

  logic        valid;
  logic        ready;
  decoded_op_t op;

  modport decode_mp (
    output valid,
    output op,
    input  ready
  );

  modport execute_mp (
    input  valid,
    input  op,
    output ready
  );

endinterface

`default_nettype wire

// File: rv_lite_credit_fifo.sv
// Circular buffer of DEPTH entries, one push and one pop per cycle
// A push while full or a pop while empty is ignored
// data_o shows the head entry and is only meaningful when not empty
`default_nettype none

module rv_lite_credit_fifo #(
  parameter type          payload_t = logic [31:0],
  parameter int unsigned  DEPTH     = 4,
  localparam int unsigned PtrW      = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CntW      = $clog2(DEPTH + 1)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  payload_t        data_i,
  input  logic            pop_i,
  output payload_t        data_o,
  output logic            empty_o,
  output logic            full_o,
  output logic [CntW-1:0] count_o
);

  payload_t        mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            wr_en;
  logic            rd_en;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CntW'(DEPTH));
  assign count_o = cnt_q;
  assign data_o  = mem_q[rd_ptr_q];
  assign wr_en   = push_i & ~full_o;
  assign rd_en   = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({wr_en, rd_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: rv_lite_decode.sv
// Input buffer, fetch enable and RV32I subset decoder
// Sender must hold a credit for every word; instr_credit_o returns one per pop
// Nothing leaves the buffer until fetch_enable_i has been high once
`default_nettype none

`include "rv_lite_consts.svh"

module rv_lite_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic [`RVL_XLEN-1:0]  instr_i,
  output logic                  instr_credit_o,
  rv_lite_op_if.decode_mp       op_o
);
  import rv_lite_pkg::*;

  localparam logic [6:0] OpcOp    = 7'b0110011;
  localparam logic [6:0] OpcOpImm = 7'b0010011;
  localparam logic [6:0] OpcLui   = 7'b0110111;

  logic                 fetch_en_q;
  logic [`RVL_XLEN-1:0] word;
  logic                 buf_empty;
  logic                 pop;
  logic                 op_valid_q;
  decoded_op_t          op_q;
  decoded_op_t          dec;

  rv_lite_credit_fifo #(
    .payload_t (logic [`RVL_XLEN-1:0]),
    .DEPTH     (`RVL_IN_DEPTH)
  ) u_in_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (instr_valid_i),
    .data_i  (instr_i),
    .pop_i   (pop),
    .data_o  (word),
    .empty_o (buf_empty),
    .full_o  (),
    .count_o ()
  );

  // Once set, stays set until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_en_q <= 1'b1;
    end
  end

  // Refill op register when empty or being taken
  assign pop            = fetch_en_q & ~buf_empty & (~op_valid_q | op_o.ready);
  assign instr_credit_o = pop;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    dec         = '0;
    dec.op      = ALU_ILLEGAL;
    dec.rd      = word[11:7];
    dec.rs1     = word[19:15];
    dec.rs2     = word[24:20];
    dec.imm     = {{20{word[31]}}, word[31:20]};
    dec.illegal = 1'b1;
    case (word[6:0])
      OpcOp: begin
        dec.illegal = 1'b0;
        case ({word[31:25], word[14:12]})
          {7'h00, 3'b000}: dec.op = ALU_ADD;
          {7'h20, 3'b000}: dec.op = ALU_SUB;
          {7'h00, 3'b111}: dec.op = ALU_AND;
          {7'h00, 3'b110}: dec.op = ALU_OR;
          {7'h00, 3'b100}: dec.op = ALU_XOR;
          {7'h00, 3'b001}: dec.op = ALU_SLL;
          {7'h00, 3'b101}: dec.op = ALU_SRL;
          {7'h00, 3'b010}: dec.op = ALU_SLT;
          default:         dec.illegal = 1'b1;
        endcase
      end
      OpcOpImm: begin
        dec.illegal = 1'b0;
        dec.use_imm = 1'b1;
        case (word[14:12])
          3'b000:  dec.op = ALU_ADD;
          3'b111:  dec.op = ALU_AND;
          3'b110:  dec.op = ALU_OR;
          3'b100:  dec.op = ALU_XOR;
          default: dec.illegal = 1'b1;
        endcase
      end
      OpcLui: begin
        dec.illegal = 1'b0;
        dec.use_imm = 1'b1;
        dec.op      = ALU_LUI;
        dec.imm     = {word[31:12], 12'b0};
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal) begin
      dec.op = ALU_ILLEGAL;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q <= 1'b0;
    end else if (pop) begin
      op_valid_q <= 1'b1;
    end else if (op_o.ready) begin
      op_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      op_q <= dec;
    end
  end

  assign op_o.valid = op_valid_q;
  assign op_o.op    = op_q;

endmodule

`default_nettype wire

// File: rv_lite_execute.sv
// Register file and ALU, two cycles from op taken to result push
// Operands are read when an op is taken, with the write in flight forwarded
// x0 reads as zero and is never written
`default_nettype none

`include "rv_lite_consts.svh"

module rv_lite_execute (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  rv_lite_op_if.execute_mp     op_i,
  input  logic                 res_room_i,
  output logic                 res_push_o,
  output rv_lite_pkg::result_t res_data_o
);
  import rv_lite_pkg::*;

  logic [`RVL_XLEN-1:0] rf_q [`RVL_NREGS];
  logic                 take;
  logic                 rf_we;
  logic [`RVL_XLEN-1:0] rs1_val;
  logic [`RVL_XLEN-1:0] rs2_val;
  logic                 ex_valid_q;
  alu_op_e              ex_op_q;
  reg_addr_t            ex_rd_q;
  logic                 ex_illegal_q;
  logic [`RVL_XLEN-1:0] ex_a_q;
  logic [`RVL_XLEN-1:0] ex_b_q;
  logic [`RVL_XLEN-1:0] alu_res;

  // Only stalls when the result buffer could overflow
  assign op_i.ready = res_room_i;
  assign take       = op_i.valid & op_i.ready;

  ////////////////////////////////////////////////////////////
  // Register file read with write forwarding
  ////////////////////////////////////////////////////////////

  assign rf_we   = ex_valid_q & ~ex_illegal_q & (ex_rd_q != '0);
  assign rs1_val = (op_i.op.rs1 == '0) ? '0 :
                   (rf_we && ex_rd_q == op_i.op.rs1) ? alu_res : rf_q[op_i.op.rs1];
  assign rs2_val = (op_i.op.rs2 == '0) ? '0 :
                   (rf_we && ex_rd_q == op_i.op.rs2) ? alu_res : rf_q[op_i.op.rs2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
    end else begin
      ex_valid_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      ex_op_q      <= op_i.op.op;
      ex_rd_q      <= op_i.op.rd;
      ex_illegal_q <= op_i.op.illegal;
      ex_a_q       <= rs1_val;
      ex_b_q       <= op_i.op.use_imm ? op_i.op.imm : rs2_val;
    end
  end

  ////////////////////////////////////////////////////////////
  // ALU and writeback
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_op_q)
      ALU_ADD: alu_res = ex_a_q + ex_b_q;
      ALU_SUB: alu_res = ex_a_q - ex_b_q;
      ALU_AND: alu_res = ex_a_q & ex_b_q;
      ALU_OR:  alu_res = ex_a_q | ex_b_q;
      ALU_XOR: alu_res = ex_a_q ^ ex_b_q;
      ALU_SLL: alu_res = ex_a_q << ex_b_q[4:0];
      ALU_SRL: alu_res = ex_a_q >> ex_b_q[4:0];
      ALU_SLT: alu_res = {{(`RVL_XLEN-1){1'b0}}, $signed(ex_a_q) < $signed(ex_b_q)};
      ALU_LUI: alu_res = ex_b_q;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rf_we) begin
      rf_q[ex_rd_q] <= alu_res;
    end
  end

  assign res_push_o         = ex_valid_q;
  assign res_data_o.rd      = ex_rd_q;
  assign res_data_o.value   = ex_illegal_q ? '0 : alu_res;
  assign res_data_o.illegal = ex_illegal_q;

endmodule

`default_nettype wire

// File: rv_lite_result.sv
// Result buffer and output credit counter
// Receiver must never return more credits than it has taken
// res_rd_o, res_data_o and res_illegal_o are valid only with res_valid_o
`default_nettype none

`include "rv_lite_consts.svh"

module rv_lite_result (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   res_push_i,
  input  rv_lite_pkg::result_t   res_data_i,
  output logic                   res_room_o,
  input  logic                   res_credit_i,
  output logic                   res_valid_o,
  output rv_lite_pkg::reg_addr_t res_rd_o,
  output logic [`RVL_XLEN-1:0]   res_data_o,
  output logic                   res_illegal_o
);
  import rv_lite_pkg::*;

  localparam int unsigned CntW  = $clog2(`RVL_RES_DEPTH + 1);
  localparam int unsigned CredW = $clog2(`RVL_RES_CREDITS + 1);

  result_t          head;
  logic             buf_empty;
  logic [CntW-1:0]  buf_count;
  logic [CntW:0]    fill;
  logic             pop;
  logic [CredW-1:0] credit_cnt_q;

  rv_lite_credit_fifo #(
    .payload_t (result_t),
    .DEPTH     (`RVL_RES_DEPTH)
  ) u_res_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (res_push_i),
    .data_i  (res_data_i),
    .pop_i   (pop),
    .data_o  (head),
    .empty_o (buf_empty),
    .full_o  (),
    .count_o (buf_count)
  );

  // Room for one more op beyond the push now landing
  assign fill       = {1'b0, buf_count} + (CntW + 1)'(res_push_i);
  assign res_room_o = (fill < (CntW + 1)'(`RVL_RES_DEPTH));

  // One entry out per cycle, each spends a credit
  assign pop = ~buf_empty & (credit_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_cnt_q <= CredW'(`RVL_RES_CREDITS);
    end else begin
      credit_cnt_q <= credit_cnt_q - CredW'(pop) + CredW'(res_credit_i);
    end
  end

  assign res_valid_o   = pop;
  assign res_rd_o      = head.rd;
  assign res_data_o    = head.value;
  assign res_illegal_o = head.illegal;

endmodule

`default_nettype wire

// File: rv_lite_top.sv
// Integer execution engine, credit-based instruction input and result output
// Sender starts with RVL_IN_DEPTH credits, engine with RVL_RES_CREDITS
// Results come back in instruction order with a variable latency
`default_nettype none

`include "rv_lite_consts.svh"

module rv_lite_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic [31:0]          instr_i,
  output logic                 instr_credit_o,
  input  logic                 res_credit_i,
  output logic                 res_valid_o,
  output logic [4:0]           res_rd_o,
  output logic [`RVL_XLEN-1:0] res_data_o,
  output logic                 res_illegal_o
);
  import rv_lite_pkg::*;

  result_t res_data;
  logic    res_push;
  logic    res_room;

  rv_lite_op_if op_if ();

  rv_lite_decode u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .op_o           (op_if.decode_mp)
  );

  rv_lite_execute u_execute (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .op_i       (op_if.execute_mp),
    .res_room_i (res_room),
    .res_push_o (res_push),
    .res_data_o (res_data)
  );

  rv_lite_result u_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_push_i    (res_push),
    .res_data_i    (res_data),
    .res_room_o    (res_room),
    .res_credit_i  (res_credit_i),
    .res_valid_o   (res_valid_o),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_illegal_o (res_illegal_o)
  );

endmodule

`default_nettype wire

// File: rv_lite_assert.sv
// Output credit rules of the result stage, bound into rv_lite_result
// Credits held are tracked from res_valid_o and res_credit_i alone
// fail_cnt counts failed assertions
`default_nettype none

`include "rv_lite_consts.svh"

module rv_lite_assert #(
  parameter int unsigned CredW = $clog2(`RVL_RES_CREDITS + 1),
  parameter int unsigned CntW  = $clog2(`RVL_RES_DEPTH + 1)
) (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             valid_i,
  input logic             credit_i,
  input logic [CredW-1:0] credit_cnt_i,
  input logic             push_i,
  input logic [CntW-1:0]  count_i
);

  int fail_cnt;
  int held_q;

  initial fail_cnt = 0;

  // Credits the engine holds, seen from the port side
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= `RVL_RES_CREDITS;
    end else begin
      held_q <= held_q - int'(valid_i) + int'(credit_i);
    end
  end

  no_output_without_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> (held_q > 0))
    else begin
      $error("result emitted with no output credit held");
      fail_cnt++;
    end

  credit_count_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_i <= CredW'(`RVL_RES_CREDITS))
    else begin
      $error("output credit count %0d above its reset value", credit_cnt_i);
      fail_cnt++;
    end

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_i != CntW'(`RVL_RES_DEPTH)))
    else begin
      $error("result pushed into a full buffer");
      fail_cnt++;
    end

endmodule

bind rv_lite_result rv_lite_assert u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      (res_valid_o),
  .credit_i     (res_credit_i),
  .credit_cnt_i (credit_cnt_q),
  .push_i       (res_push_i),
  .count_i      (buf_count)
);

`default_nettype wire

// File: tb_rv_lite_checker.sv
// Reference model of the engine, fed from the DUT ports
// Every word seen with instr_valid_i is taken as accepted, in order
`default_nettype none

`include "rv_lite_consts.svh"

module tb_rv_lite_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic        instr_credit_i,
  input  logic        res_valid_i,
  input  logic [4:0]  res_rd_i,
  input  logic [31:0] res_data_i,
  input  logic        res_illegal_i,
  output int          errors_o,
  output int          checked_o,
  output int          pending_o,
  output int          credits_o
);
  import rv_lite_pkg::*;

  logic [31:0] model_rf [32];
  result_t     expect_q [$];
  int          err_cnt;
  int          chk_cnt;
  int          word_cnt;
  int          cred_cnt;

  initial begin
    foreach (model_rf[i]) begin
      model_rf[i] = '0;
    end
    err_cnt  = 0;
    chk_cnt  = 0;
    word_cnt = 0;
    cred_cnt = 0;
  end

  assign errors_o  = err_cnt;
  assign checked_o = chk_cnt;
  assign pending_o = word_cnt - chk_cnt;
  assign credits_o = cred_cnt;

  // Expected result from the instruction encoding and the source values
  function automatic result_t predict(input logic [31:0] w, input logic [31:0] a,
                                      input logic [31:0] b);
    result_t     r;
    logic [31:0] imm;
    imm       = {{20{w[31]}}, w[31:20]};
    r.rd      = w[11:7];
    r.value   = '0;
    r.illegal = 1'b0;
    if (w[6:0] == 7'h33 && w[31:25] == 7'h20 && w[14:12] == 3'b000) begin
      r.value = a - b;
    end else if (w[6:0] == 7'h33 && w[31:25] == 7'h00) begin
      case (w[14:12])
        3'b000:  r.value = a + b;
        3'b001:  r.value = a << b[4:0];
        3'b010:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  r.value = a ^ b;
        3'b101:  r.value = a >> b[4:0];
        3'b110:  r.value = a | b;
        3'b111:  r.value = a & b;
        default: r.illegal = 1'b1;
      endcase
    end else if (w[6:0] == 7'h13) begin
      case (w[14:12])
        3'b000:  r.value = a + imm;
        3'b100:  r.value = a ^ imm;
        3'b110:  r.value = a | imm;
        3'b111:  r.value = a & imm;
        default: r.illegal = 1'b1;
      endcase
    end else if (w[6:0] == 7'h37) begin
      r.value = {w[31:12], 12'b0};
    end else begin
      r.illegal = 1'b1;
    end
    if (r.illegal) begin
      r.value = '0;
    end
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  always @(posedge clk_i) begin
    result_t e;
    result_t r;
    if (rst_ni && res_valid_i) begin
      if (expect_q.size() == 0) begin
        $display("at %0t: result seen with no instruction outstanding", $time);
        err_cnt++;
      end else begin
        e = expect_q.pop_front();
        chk_cnt++;
        check_field("res_rd_o", 32'(e.rd), 32'(res_rd_i));
        check_field("res_data_o", e.value, res_data_i);
        check_field("res_illegal_o", 32'(e.illegal), 32'(res_illegal_i));
      end
    end
    if (rst_ni && instr_valid_i) begin
      r = predict(instr_i, model_rf[instr_i[19:15]], model_rf[instr_i[24:20]]);
      if (!r.illegal && r.rd != 5'd0) begin
        model_rf[r.rd] = r.value;
      end
      expect_q.push_back(r);
      word_cnt++;
    end
    if (rst_ni && instr_credit_i) begin
      cred_cnt++;
    end
    // Words held by the engine must stay within the sender's credits
    if (word_cnt - cred_cnt < 0 || word_cnt - cred_cnt > `RVL_IN_DEPTH) begin
      $display("at %0t: %0d words outstanding at the input, outside 0..%0d",
               $time, word_cnt - cred_cnt, `RVL_IN_DEPTH);
      err_cnt++;
    end
  end

endmodule

`default_nettype wire

// File: tb_rv_lite_top.sv
// Testbench for the integer execution engine, seeded random stimulus
// Only x0..x15 are used, and they are written before any test reads them
// Inputs change on the falling edge; the checker samples on the rising edge
`default_nettype none

`include "rv_lite_consts.svh"

module tb_rv_lite_top;

  localparam int ClkPeriod     = 8;
  localparam int ResetCycles   = 16;
  localparam int NumInstr      = 4 + 90 + 40 + 40 + 40 + 8;
  localparam int TimeoutCycles = NumInstr * 40 + ResetCycles;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        instr_credit_o;
  logic        res_credit_i;
  logic        res_valid_o;
  logic [4:0]  res_rd_o;
  logic [31:0] res_data_o;
  logic        res_illegal_o;

  int   in_credits;
  int   owed_credits;
  int   words_sent;
  int   tb_errors;
  int   prev_errors;
  logic hold_credits;
  int   chk_errors;
  int   chk_checked;
  int   chk_pending;
  int   chk_credits;

  rv_lite_top i_rv_lite_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .res_credit_i   (res_credit_i),
    .res_valid_o    (res_valid_o),
    .res_rd_o       (res_rd_o),
    .res_data_o     (res_data_o),
    .res_illegal_o  (res_illegal_o)
  );

  tb_rv_lite_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_i (instr_credit_o),
    .res_valid_i    (res_valid_o),
    .res_rd_i       (res_rd_o),
    .res_data_i     (res_data_o),
    .res_illegal_i  (res_illegal_o),
    .errors_o       (chk_errors),
    .checked_o      (chk_checked),
    .pending_o      (chk_pending),
    .credits_o      (chk_credits)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Instruction builders
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [4:0] random_reg();
    return 5'($urandom % 16);
  endfunction

  function automatic logic [31:0] legal_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    logic [31:0] w;
    case ($urandom % 13)
      0:       w = r_type(7'h00, rs2, rs1, 3'b000, rd);
      1:       w = r_type(7'h20, rs2, rs1, 3'b000, rd);
      2:       w = r_type(7'h00, rs2, rs1, 3'b111, rd);
      3:       w = r_type(7'h00, rs2, rs1, 3'b110, rd);
      4:       w = r_type(7'h00, rs2, rs1, 3'b100, rd);
      5:       w = r_type(7'h00, rs2, rs1, 3'b001, rd);
      6:       w = r_type(7'h00, rs2, rs1, 3'b101, rd);
      7:       w = r_type(7'h00, rs2, rs1, 3'b010, rd);
      8:       w = i_type(12'($urandom), rs1, 3'b000, rd);
      9:       w = i_type(12'($urandom), rs1, 3'b111, rd);
      10:      w = i_type(12'($urandom), rs1, 3'b110, rd);
      11:      w = i_type(12'($urandom), rs1, 3'b100, rd);
      default: w = lui(20'($urandom), rd);
    endcase
    return w;
  endfunction

  // Unknown opcode, unsupported funct7, or unsupported OP-IMM funct3
  function automatic logic [31:0] illegal_word();
    logic [31:0] w;
    logic [6:0]  opc;
    w = $urandom;
    case ($urandom % 3)
      0: begin
        opc = 7'($urandom);
        while (opc == 7'h33 || opc == 7'h13 || opc == 7'h37) begin
          opc = 7'($urandom);
        end
        w[6:0] = opc;
      end
      1: begin
        w[6:0]   = 7'h33;
        w[31:25] = 7'h20;
        w[14:12] = 3'($urandom % 7 + 1);
      end
      default: begin
        w[6:0] = 7'h13;
        case ($urandom % 4)
          0:       w[14:12] = 3'b001;
          1:       w[14:12] = 3'b010;
          2:       w[14:12] = 3'b011;
          default: w[14:12] = 3'b101;
        endcase
      end
    endcase
    w[11:7] = random_reg();
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Credit handling on both sides
  ////////////////////////////////////////////////////////////

  task automatic send_word(input logic [31:0] w);
    while (in_credits == 0) begin
      @(negedge clk_i);
    end
    instr_valid_i = 1'b1;
    instr_i       = w;
    in_credits--;
    words_sent++;
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  always @(posedge clk_i) begin
    if (instr_credit_o) begin
      in_credits++;
    end
    if (res_valid_o) begin
      owed_credits++;
    end
  end

  // Receiver hands credits back after a random delay
  always @(negedge clk_i) begin
    if (rst_ni && !hold_credits && owed_credits > 0 && ($urandom % 3) == 0) begin
      res_credit_i = 1'b1;
      owed_credits--;
    end else begin
      res_credit_i = 1'b0;
    end
  end

  task automatic wait_drain();
    while (chk_pending != 0 || in_credits != `RVL_IN_DEPTH || owed_credits != 0) begin
      @(negedge clk_i);
    end
  endtask

  function automatic int total_errors();
    return chk_errors + tb_errors + i_rv_lite_top.u_result.u_assert.fail_cnt;
  endfunction

  task automatic end_test(input string name);
    int errs;
    errs = total_errors();
    $display("test %-14s %s, %0d results checked, %0d new errors", name,
             (errs == prev_errors) ? "ok" : "failed", chk_checked, errs - prev_errors);
    prev_errors = errs;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          i;
    int          base_words;
    int          base_checked;
    logic [4:0]  rd;
    logic [4:0]  prev_rd;
    logic [31:0] w;
    void'($urandom(93968));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    res_credit_i   = 1'b0;
    hold_credits   = 1'b0;
    in_credits     = `RVL_IN_DEPTH;
    owed_credits   = 0;
    words_sent     = 0;
    tb_errors      = 0;
    prev_errors    = 0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;

    // Words wait in the input buffer until fetch enable is seen
    for (i = 0; i < 4; i++) begin
      send_word(i_type(12'($urandom), 5'd0, 3'b000, 5'(1 + i)));
    end
    repeat (20) @(negedge clk_i);
    if (chk_checked != 0 || chk_credits != 0) begin
      $display("engine ran before fetch enable: %0d results, %0d credits returned",
               chk_checked, chk_credits);
      tb_errors++;
    end
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    fetch_enable_i = 1'b0;
    wait_drain();
    if (chk_checked != 4) begin
      $display("expected 4 results after fetch enable, saw %0d", chk_checked);
      tb_errors++;
    end
    end_test("fetch_enable");

    for (i = 1; i < 16; i++) begin
      send_word(lui(20'($urandom), 5'(i)));
      send_word(i_type(12'($urandom), 5'(i), 3'b100, 5'(i)));
    end
    for (i = 0; i < 60; i++) begin
      send_word(legal_word(random_reg(), random_reg(), random_reg()));
    end
    wait_drain();
    end_test("alu_random");

    prev_rd = 5'd1;
    for (i = 0; i < 40; i++) begin
      rd = 5'(1 + $urandom % 15);
      send_word(legal_word(rd, prev_rd, ($urandom % 2) ? prev_rd : random_reg()));
      prev_rd = rd;
    end
    wait_drain();
    end_test("dependent");

    // Each illegal word is followed by a read of its rd
    for (i = 0; i < 20; i++) begin
      w = illegal_word();
      send_word(w);
      send_word(r_type(7'h00, 5'd0, w[11:7], 3'b000, 5'd0));
    end
    wait_drain();
    end_test("illegal");

    base_words   = words_sent;
    base_checked = chk_checked;
    for (i = 0; i < 40; i++) begin
      send_word(legal_word(random_reg(), random_reg(), random_reg()));
    end
    wait_drain();
    if (chk_credits != words_sent) begin
      $display("input credits returned %0d, words sent %0d", chk_credits, words_sent);
      tb_errors++;
    end
    if (chk_checked - base_checked != words_sent - base_words) begin
      $display("burst of %0d words gave %0d results", words_sent - base_words,
               chk_checked - base_checked);
      tb_errors++;
    end
    end_test("input_credits");

    hold_credits = 1'b1;
    base_checked = chk_checked;
    for (i = 0; i < 8; i++) begin
      send_word(legal_word(random_reg(), random_reg(), random_reg()));
    end
    repeat (40) @(negedge clk_i);
    if (chk_checked - base_checked > `RVL_RES_CREDITS) begin
      $display("%0d results emitted while output credits were withheld",
               chk_checked - base_checked);
      tb_errors++;
    end
    hold_credits = 1'b0;
    wait_drain();
    if (chk_checked - base_checked != 8) begin
      $display("8 words under back-pressure gave %0d results", chk_checked - base_checked);
      tb_errors++;
    end
    end_test("back_pressure");

    $display("summary: %0d words sent, %0d results checked, %0d errors",
             words_sent, chk_checked, total_errors());
    if (total_errors() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
rv_lite_pkg.sv
rv_lite_op_if.sv
rv_lite_credit_fifo.sv
rv_lite_decode.sv
rv_lite_execute.sv
rv_lite_result.sv
rv_lite_top.sv
rv_lite_assert.sv
tb_rv_lite_checker.sv
tb_rv_lite_top.sv

// File: Bender.yml
package:
  name: rv_lite

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_lite_pkg.sv
      - rv_lite_op_if.sv
      - rv_lite_credit_fifo.sv
      - rv_lite_decode.sv
      - rv_lite_execute.sv
      - rv_lite_result.sv
      - rv_lite_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_lite_assert.sv
      - tb_rv_lite_checker.sv
      - tb_rv_lite_top.sv
